//--- src/soc_interconnect_pkg.sv
/*
 * Shared widths, region constants and bus structs of the SoC memory interconnect.
 * All RTL files refer to these items by scoped name through this one package.
 */

package soc_interconnect_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus geometry
    //////////////////////////////////////////////////////////////////////

    // Word-wide TCDM bus
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // Two masters share four banks
    localparam int unsigned NUM_MASTERS     = 2;
    localparam int unsigned NUM_BANKS       = 4;
    localparam int unsigned BANK_SEL_WIDTH  = 2;
    localparam int unsigned BANK_ADDR_WIDTH = 13;
    localparam int unsigned MST_SEL_WIDTH   = 1;

    // Byte offset inside one word, below the bank select bits
    localparam int unsigned WORD_OFFSET_WIDTH = 2;

    //////////////////////////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////////////////////////

    // Interleaved SRAM region, 128 KiB spread word by word over the banks
    localparam logic [ADDR_WIDTH-1:0] INTLV_BASE = 32'h1C00_0000;
    localparam logic [ADDR_WIDTH-1:0] INTLV_SIZE = 32'h0002_0000;

    // Read data returned for any access outside the region
    localparam logic [DATA_WIDTH-1:0] BUS_ERROR_WORD = 32'hBADA_CCE5;

    //////////////////////////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////////////////////////

    // Master request, payload held stable until gnt
    typedef struct packed {
        logic                  req;
        logic [ADDR_WIDTH-1:0] addr;
        logic                  we;
        logic [BE_WIDTH-1:0]   be;
        logic [DATA_WIDTH-1:0] wdata;
    } tcdm_req_t;

    // Response to a master, r_opc flags a bus error
    typedef struct packed {
        logic                  gnt;
        logic                  r_valid;
        logic [DATA_WIDTH-1:0] r_rdata;
        logic                  r_opc;
    } tcdm_rsp_t;

    // Request towards one bank, addr is the word index inside that bank
    typedef struct packed {
        logic                       req;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic                       we;
        logic [BE_WIDTH-1:0]        be;
        logic [DATA_WIDTH-1:0]      wdata;
    } bank_req_t;

    // Bank answer, always one cycle after the bank grant
    typedef struct packed {
        logic                  r_valid;
        logic [DATA_WIDTH-1:0] r_rdata;
    } bank_rsp_t;

endpackage

//--- src/tcdm_region_demux.sv
/*
 * Per-master address decode in front of the interleaved crossbar.
 * In-region requests go to the crossbar, all others to the error slave,
 * and the two response paths are merged back onto the master port.
 */

`timescale 1ns/1ps

module tcdm_region_demux (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t mst_req_i,
    input  soc_interconnect_pkg::tcdm_rsp_t xbar_rsp_i,
    input  soc_interconnect_pkg::tcdm_rsp_t err_rsp_i,
    output soc_interconnect_pkg::tcdm_rsp_t mst_rsp_o,
    output soc_interconnect_pkg::tcdm_req_t xbar_req_o,
    output soc_interconnect_pkg::tcdm_req_t err_req_o
);

    // High when the current address falls inside the interleaved region
    logic in_region;
    // Grant taken from whichever path the address selects
    logic gnt;
    // Remembers which path took the last granted request
    logic xbar_sel_q;

    //////////////////////////////////////////////////////////////////////
    // Request path
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Region check against the fixed base and size
        in_region = (mst_req_i.addr >= soc_interconnect_pkg::INTLV_BASE) &&
                    (mst_req_i.addr <  soc_interconnect_pkg::INTLV_BASE +
                                       soc_interconnect_pkg::INTLV_SIZE);

        // Payload goes to both sides, only one of them sees req
        xbar_req_o     = mst_req_i;
        xbar_req_o.req = mst_req_i.req & in_region;
        err_req_o      = mst_req_i;
        err_req_o.req  = mst_req_i.req & ~in_region;

        // The master sees the grant of the path it is talking to
        gnt = in_region ? xbar_rsp_i.gnt : err_rsp_i.gnt;
    end

    //////////////////////////////////////////////////////////////////////
    // Response path
    //////////////////////////////////////////////////////////////////////

    // The response arrives one cycle after the grant, so the path
    // choice is captured on the granted edge and used in the next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            xbar_sel_q <= 1'b0;
        end else if (mst_req_i.req && gnt) begin
            xbar_sel_q <= in_region;
        end
    end

    always_comb begin
        mst_rsp_o.gnt = gnt;
        // A new request may be granted on the other path in this cycle,
        // the response still belongs to the registered one
        if (xbar_sel_q) begin
            mst_rsp_o.r_valid = xbar_rsp_i.r_valid;
            mst_rsp_o.r_rdata = xbar_rsp_i.r_rdata;
            mst_rsp_o.r_opc   = xbar_rsp_i.r_opc;
        end else begin
            mst_rsp_o.r_valid = err_rsp_i.r_valid;
            mst_rsp_o.r_rdata = err_rsp_i.r_rdata;
            mst_rsp_o.r_opc   = err_rsp_i.r_opc;
        end
    end

endmodule

//--- src/tcdm_error_slave.sv
/*
 * Error target for out-of-region accesses.
 * Grants every request at once and answers one cycle later with the
 * bus-error word and the error flag set. Writes are dropped.
 */

`timescale 1ns/1ps

module tcdm_error_slave (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t req_i,
    output soc_interconnect_pkg::tcdm_rsp_t rsp_o
);

    // One response owed for the request granted on the last edge
    logic pending_q;

    // Every request is accepted, so one is granted on every req edge
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= req_i.req;
        end
    end

    always_comb begin
        // No back-pressure here, the grant follows req directly
        rsp_o.gnt     = req_i.req;
        rsp_o.r_valid = pending_q;
        // Read data and error flag only show while a response is due
        rsp_o.r_rdata = pending_q ? soc_interconnect_pkg::BUS_ERROR_WORD : '0;
        rsp_o.r_opc   = pending_q;
    end

endmodule

//--- src/bank_rr_arbiter.sv
/*
 * Round-robin arbiter for one bank among all masters.
 * The search starts at a rotating pointer and wraps around. The pointer
 * moves past the winner on every edge where the bank accepts a request.
 */

`timescale 1ns/1ps

module bank_rr_arbiter (
    input  logic                                           clk_i,
    input  logic                                           arst_n_i,
    input  logic [soc_interconnect_pkg::NUM_MASTERS-1:0]   req_i,
    input  logic                                           ready_i,
    output logic [soc_interconnect_pkg::NUM_MASTERS-1:0]   gnt_o,
    output logic [soc_interconnect_pkg::MST_SEL_WIDTH-1:0] winner_o
);

    // Master with the highest priority in this cycle
    logic [soc_interconnect_pkg::MST_SEL_WIDTH-1:0] ptr_q;
    logic [soc_interconnect_pkg::MST_SEL_WIDTH-1:0] winner;
    logic                                           any_req;

    //////////////////////////////////////////////////////////////////////
    // Winner search
    //////////////////////////////////////////////////////////////////////

    // The winner does not depend on ready_i, so the payload steered to
    // the bank stays stable while the bank decides on its grant
    always_comb begin
        int unsigned idx;
        winner  = ptr_q;
        any_req = 1'b0;
        for (int unsigned i = 0; i < soc_interconnect_pkg::NUM_MASTERS; i++) begin
            idx = (ptr_q + i) % soc_interconnect_pkg::NUM_MASTERS;
            if (!any_req && req_i[idx]) begin
                winner  = soc_interconnect_pkg::MST_SEL_WIDTH'(idx);
                any_req = 1'b1;
            end
        end
    end

    always_comb begin
        gnt_o = '0;
        // No one is granted while the bank holds off
        if (any_req && ready_i) begin
            gnt_o[winner] = 1'b1;
        end
    end

    assign winner_o = winner;

    //////////////////////////////////////////////////////////////////////
    // Priority pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q <= '0;
        end else if (any_req && ready_i) begin
            // The master after the winner gets first pick next time
            if (winner == soc_interconnect_pkg::NUM_MASTERS - 1) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= winner + 1'b1;
            end
        end
    end

endmodule

//--- src/interleaved_xbar.sv
/*
 * Full crossbar from the masters to the interleaved SRAM banks.
 * The bank comes from the low word-address bits, each bank has its own
 * round-robin arbiter, and a registered owner routes the bank answer back.
 */

`timescale 1ns/1ps

module interleaved_xbar (
    input  logic                                          clk_i,
    input  logic                                          arst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t               mst_req_i
                                                          [soc_interconnect_pkg::NUM_MASTERS],
    input  logic [soc_interconnect_pkg::NUM_BANKS-1:0]    bank_gnt_i,
    input  soc_interconnect_pkg::bank_rsp_t               bank_rsp_i
                                                          [soc_interconnect_pkg::NUM_BANKS],
    output soc_interconnect_pkg::tcdm_rsp_t               mst_rsp_o
                                                          [soc_interconnect_pkg::NUM_MASTERS],
    output soc_interconnect_pkg::bank_req_t               bank_req_o
                                                          [soc_interconnect_pkg::NUM_BANKS]
);

    // Decoded target of each master
    logic [soc_interconnect_pkg::BANK_SEL_WIDTH-1:0]  mst_bank [soc_interconnect_pkg::NUM_MASTERS];
    logic [soc_interconnect_pkg::BANK_ADDR_WIDTH-1:0] mst_word [soc_interconnect_pkg::NUM_MASTERS];

    // Per-bank arbitration signals
    logic [soc_interconnect_pkg::NUM_MASTERS-1:0]   bank_req_vec [soc_interconnect_pkg::NUM_BANKS];
    logic [soc_interconnect_pkg::NUM_MASTERS-1:0]   bank_win_gnt [soc_interconnect_pkg::NUM_BANKS];
    logic [soc_interconnect_pkg::MST_SEL_WIDTH-1:0] bank_winner  [soc_interconnect_pkg::NUM_BANKS];

    // Master that owns the response due from each bank in this cycle
    logic [soc_interconnect_pkg::MST_SEL_WIDTH-1:0] owner_q [soc_interconnect_pkg::NUM_BANKS];
    logic [soc_interconnect_pkg::NUM_BANKS-1:0]     owner_vld_q;

    //////////////////////////////////////////////////////////////////////
    // Address decode and per-bank request vectors
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [soc_interconnect_pkg::ADDR_WIDTH-1:0] offset;
        for (int m = 0; m < soc_interconnect_pkg::NUM_MASTERS; m++) begin
            // Offset into the region, consecutive words land on consecutive banks
            offset      = mst_req_i[m].addr - soc_interconnect_pkg::INTLV_BASE;
            mst_bank[m] = offset[soc_interconnect_pkg::WORD_OFFSET_WIDTH +:
                                 soc_interconnect_pkg::BANK_SEL_WIDTH];
            mst_word[m] = offset[soc_interconnect_pkg::WORD_OFFSET_WIDTH +
                                 soc_interconnect_pkg::BANK_SEL_WIDTH +:
                                 soc_interconnect_pkg::BANK_ADDR_WIDTH];
        end
        for (int b = 0; b < soc_interconnect_pkg::NUM_BANKS; b++) begin
            for (int m = 0; m < soc_interconnect_pkg::NUM_MASTERS; m++) begin
                bank_req_vec[b][m] = mst_req_i[m].req &&
                    (mst_bank[m] == soc_interconnect_pkg::BANK_SEL_WIDTH'(b));
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Arbitration and bank side
    //////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < soc_interconnect_pkg::NUM_BANKS; b++) begin : gen_bank
        bank_rr_arbiter i_bank_arb (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (bank_req_vec[b]),
            .ready_i  (bank_gnt_i[b]),
            .gnt_o    (bank_win_gnt[b]),
            .winner_o (bank_winner[b])
        );
    end

    // The bank sees the payload of the current arbitration winner
    always_comb begin
        for (int b = 0; b < soc_interconnect_pkg::NUM_BANKS; b++) begin
            bank_req_o[b].req   = |bank_req_vec[b];
            bank_req_o[b].addr  = mst_word[bank_winner[b]];
            bank_req_o[b].we    = mst_req_i[bank_winner[b]].we;
            bank_req_o[b].be    = mst_req_i[bank_winner[b]].be;
            bank_req_o[b].wdata = mst_req_i[bank_winner[b]].wdata;
        end
    end

    // Owner of each granted transfer, valid for exactly the next cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owner_vld_q <= '0;
            for (int b = 0; b < soc_interconnect_pkg::NUM_BANKS; b++) begin
                owner_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < soc_interconnect_pkg::NUM_BANKS; b++) begin
                owner_vld_q[b] <= |bank_win_gnt[b];
                owner_q[b]     <= bank_winner[b];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Master side
    //////////////////////////////////////////////////////////////////////

    // A master has one request per cycle, so at most one bank answers it
    always_comb begin
        for (int m = 0; m < soc_interconnect_pkg::NUM_MASTERS; m++) begin
            mst_rsp_o[m] = '0;
            for (int b = 0; b < soc_interconnect_pkg::NUM_BANKS; b++) begin
                if (bank_win_gnt[b][m]) begin
                    mst_rsp_o[m].gnt = 1'b1;
                end
                if (owner_vld_q[b] && bank_rsp_i[b].r_valid &&
                    (owner_q[b] == soc_interconnect_pkg::MST_SEL_WIDTH'(m))) begin
                    mst_rsp_o[m].r_valid = 1'b1;
                    mst_rsp_o[m].r_rdata = bank_rsp_i[b].r_rdata;
                end
            end
        end
    end

endmodule

//--- src/soc_interconnect.sv
/*
 * Top level of the SoC memory interconnect.
 * Each master passes through its own region decoder and error slave,
 * then all masters meet the four SRAM banks in the interleaved crossbar.
 */

`timescale 1ns/1ps

module soc_interconnect (
    input  logic                                       clk_i,
    input  logic                                       arst_n_i,
    input  soc_interconnect_pkg::tcdm_req_t            mst_req_i
                                                       [soc_interconnect_pkg::NUM_MASTERS],
    input  logic [soc_interconnect_pkg::NUM_BANKS-1:0] bank_gnt_i,
    input  soc_interconnect_pkg::bank_rsp_t            bank_rsp_i
                                                       [soc_interconnect_pkg::NUM_BANKS],
    output soc_interconnect_pkg::tcdm_rsp_t            mst_rsp_o
                                                       [soc_interconnect_pkg::NUM_MASTERS],
    output soc_interconnect_pkg::bank_req_t            bank_req_o
                                                       [soc_interconnect_pkg::NUM_BANKS]
);

    // Decoder to crossbar links, one per master
    soc_interconnect_pkg::tcdm_req_t xbar_req [soc_interconnect_pkg::NUM_MASTERS];
    soc_interconnect_pkg::tcdm_rsp_t xbar_rsp [soc_interconnect_pkg::NUM_MASTERS];

    // Decoder to error slave links, one per master
    soc_interconnect_pkg::tcdm_req_t err_req [soc_interconnect_pkg::NUM_MASTERS];
    soc_interconnect_pkg::tcdm_rsp_t err_rsp [soc_interconnect_pkg::NUM_MASTERS];

    //////////////////////////////////////////////////////////////////////
    // Region decode, one decoder and one error slave per master
    //////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < soc_interconnect_pkg::NUM_MASTERS; m++) begin : gen_master
        tcdm_region_demux i_region_demux (
            .clk_i      (clk_i),
            .arst_n_i   (arst_n_i),
            .mst_req_i  (mst_req_i[m]),
            .xbar_rsp_i (xbar_rsp[m]),
            .err_rsp_i  (err_rsp[m]),
            .mst_rsp_o  (mst_rsp_o[m]),
            .xbar_req_o (xbar_req[m]),
            .err_req_o  (err_req[m])
        );

        // Out-of-region accesses end here with a bus error
        tcdm_error_slave i_error_slave (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (err_req[m]),
            .rsp_o    (err_rsp[m])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Interleaved crossbar to the SRAM banks
    //////////////////////////////////////////////////////////////////////

    interleaved_xbar i_interleaved_xbar (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .mst_req_i  (xbar_req),
        .bank_gnt_i (bank_gnt_i),
        .bank_rsp_i (bank_rsp_i),
        .mst_rsp_o  (xbar_rsp),
        .bank_req_o (bank_req_o)
    );

endmodule

//--- verification/tb_soc_interconnect.sv
/*
 * Self-checking testbench of the SoC memory interconnect.
 * Applies a table of master accesses row by row, models the four SRAM banks,
 * and checks every master response and bank request against a reference.
 */

`timescale 1ns/1ps

module tb_soc_interconnect;

    localparam int unsigned NM           = soc_interconnect_pkg::NUM_MASTERS;
    localparam int unsigned NB           = soc_interconnect_pkg::NUM_BANKS;
    localparam int unsigned BANK_WORDS   = 1 << soc_interconnect_pkg::BANK_ADDR_WIDTH;
    localparam int unsigned RESET_CYCLES = 8;
    localparam int unsigned N_ROWS       = 24;
    // Rows from here on see a random bank grant
    localparam int unsigned BP_ROW       = 17;
    localparam int unsigned CYCLE_LIMIT  = RESET_CYCLES + N_ROWS * 16;

    // One master access where err marks an expected error response
    typedef struct packed {
        logic        op;
        logic        we;
        logic        err;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
    } stim_t;

    localparam stim_t NOP = '0;

    logic clk;
    logic arst_n;

    soc_interconnect_pkg::tcdm_req_t mst_req  [NM];
    soc_interconnect_pkg::tcdm_rsp_t mst_rsp  [NM];
    logic [NB-1:0]                   bank_gnt;
    soc_interconnect_pkg::bank_rsp_t bank_rsp [NB];
    soc_interconnect_pkg::bank_req_t bank_req [NB];

    // Stimulus table with one column per master
    stim_t stim [N_ROWS][NM];

    // Bank contents and the reference keyed by full word address
    logic [31:0] bank_mem [NB][BANK_WORDS];
    logic [31:0] ref_mem  [logic [29:0]];

    int unsigned row;
    logic [NM-1:0] done;
    // Round-robin pointer expected in each bank arbiter
    logic [soc_interconnect_pkg::MST_SEL_WIDTH-1:0] ptr [NB];

    // Response owed to each master in the coming cycle
    logic [NM-1:0] exp_vld;
    logic [NM-1:0] exp_err;
    logic [NM-1:0] exp_rd;
    logic [31:0]   exp_dat [NM];

    soc_interconnect_pkg::bank_rsp_t rsp_nxt [NB];
    logic [NB-1:0] gnt_nxt;
    logic [15:0]   lfsr;
    int unsigned   cycles = 0;

    soc_interconnect dut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .mst_req_i  (mst_req),
        .bank_gnt_i (bank_gnt),
        .bank_rsp_i (bank_rsp),
        .mst_rsp_o  (mst_rsp),
        .bank_req_o (bank_req)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////

    // Initial memory content that differs for every word address
    function automatic logic [31:0] fill_word(input logic [29:0] wa);
        return (32'(wa) * 32'h9E37_79B1) ^ 32'h5A5A_5A5A;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  be);
        logic [31:0] res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic stim_t acc(input logic we, input logic err, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [3:0] be);
        stim_t s;
        s.op    = 1'b1;
        s.we    = we;
        s.err   = err;
        s.addr  = addr;
        s.wdata = wdata;
        s.be    = be;
        return s;
    endfunction

    // Consecutive words of the region go to consecutive banks
    function automatic logic [1:0] bank_of(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - soc_interconnect_pkg::INTLV_BASE;
        return offset[3:2];
    endfunction

    function automatic logic [12:0] word_of(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - soc_interconnect_pkg::INTLV_BASE;
        return offset[16:4];
    endfunction

    function automatic logic [31:0] ref_read(input logic [29:0] wa);
        return ref_mem.exists(wa) ? ref_mem[wa] : fill_word(wa);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////

    task automatic check_rsp(input soc_interconnect_pkg::tcdm_rsp_t got,
                             input soc_interconnect_pkg::tcdm_rsp_t exp,
                             input int m, input bit data_care);
        if (got.gnt !== exp.gnt || got.r_valid !== exp.r_valid ||
            got.r_opc !== exp.r_opc || (data_care && got.r_rdata !== exp.r_rdata)) begin
            fail_run($sformatf(
                "FAIL @ %0t: master %0d gnt/valid/opc/data %b/%b/%b/%h, exp %b/%b/%b/%h",
                $time, m, got.gnt, got.r_valid, got.r_opc, got.r_rdata,
                exp.gnt, exp.r_valid, exp.r_opc, exp.r_rdata));
        end
    endtask

    // Payload only matters while the bank sees a request
    task automatic check_bank_req(input soc_interconnect_pkg::bank_req_t got,
                                  input soc_interconnect_pkg::bank_req_t exp, input int b);
        if (got.req !== exp.req || (exp.req && got !== exp)) begin
            fail_run($sformatf("FAIL @ %0t: bank %0d request %h, expected %h",
                $time, b, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Row handling and per-cycle model
    ////////////////////////////////////////////////////////////////////////

    task automatic load_row();
        for (int m = 0; m < NM; m++) begin
            done[m] = (row >= N_ROWS) || !stim[row][m].op;
        end
    endtask

    function automatic soc_interconnect_pkg::tcdm_req_t drive_req(input int m);
        soc_interconnect_pkg::tcdm_req_t r;
        r = '0;
        if (!done[m]) begin
            r.req   = 1'b1;
            r.addr  = stim[row][m].addr;
            r.we    = stim[row][m].we;
            r.be    = stim[row][m].be;
            r.wdata = stim[row][m].wdata;
        end
        return r;
    endfunction

    // Bank grants for the next cycle with one LFSR step per bank in the late rows
    task automatic next_bank_gnt();
        for (int b = 0; b < NB; b++) begin
            if (row >= BP_ROW) begin
                gnt_nxt[b] = lfsr[0];
                lfsr       = lfsr_step(lfsr);
            end else begin
                gnt_nxt[b] = 1'b1;
            end
        end
    endtask

    // Runs between edges when every DUT output is settled
    task automatic check_and_advance();
        logic [NM-1:0] req_vec [NB];
        logic [soc_interconnect_pkg::MST_SEL_WIDTH-1:0] win [NB];
        logic [NM-1:0] gnt_exp;
        soc_interconnect_pkg::bank_req_t exp_breq;
        soc_interconnect_pkg::tcdm_rsp_t exp_rsp;
        stim_t s;
        logic [29:0] wa;
        for (int b = 0; b < NB; b++) begin
            req_vec[b] = '0;
        end
        for (int m = 0; m < NM; m++) begin
            if (!done[m] && !stim[row][m].err) begin
                req_vec[bank_of(stim[row][m].addr)][m] = 1'b1;
            end
        end
        // The pointer master wins if it asks and the other one wins otherwise
        for (int b = 0; b < NB; b++) begin
            win[b]   = req_vec[b][ptr[b]] ? ptr[b] : ptr[b] + 1'b1;
            exp_breq = '0;
            if (|req_vec[b]) begin
                s              = stim[row][win[b]];
                exp_breq.req   = 1'b1;
                exp_breq.addr  = word_of(s.addr);
                exp_breq.we    = s.we;
                exp_breq.be    = s.be;
                exp_breq.wdata = s.wdata;
            end
            check_bank_req(bank_req[b], exp_breq, b);
        end
        for (int m = 0; m < NM; m++) begin
            s          = stim[row < N_ROWS ? row : 0][m];
            gnt_exp[m] = !done[m] && (s.err || (win[bank_of(s.addr)] == m &&
                                                bank_gnt[bank_of(s.addr)]));
            exp_rsp.gnt     = gnt_exp[m];
            exp_rsp.r_valid = exp_vld[m];
            exp_rsp.r_opc   = exp_vld[m] & exp_err[m];
            exp_rsp.r_rdata = exp_err[m] ? soc_interconnect_pkg::BUS_ERROR_WORD : exp_dat[m];
            check_rsp(mst_rsp[m], exp_rsp, m, exp_vld[m] && (exp_err[m] || exp_rd[m]));
        end
        // Grants seen now become the responses of the next cycle
        for (int m = 0; m < NM; m++) begin
            exp_vld[m] = gnt_exp[m];
            if (gnt_exp[m]) begin
                s          = stim[row][m];
                done[m]    = 1'b1;
                exp_err[m] = s.err;
                exp_rd[m]  = !s.we;
                wa         = s.addr[31:2];
                if (!s.err && s.we) begin
                    ref_mem[wa] = merge_bytes(ref_read(wa), s.wdata, s.be);
                end else if (!s.err) begin
                    exp_dat[m] = ref_read(wa);
                end
            end
        end
        for (int b = 0; b < NB; b++) begin
            if (|req_vec[b] && bank_gnt[b]) begin
                ptr[b] = win[b] + 1'b1;
            end
            // Bank model answers whatever the DUT presents on a granted edge
            rsp_nxt[b] = '0;
            if (bank_req[b].req && bank_gnt[b]) begin
                rsp_nxt[b].r_valid = 1'b1;
                rsp_nxt[b].r_rdata = bank_mem[b][bank_req[b].addr];
                if (bank_req[b].we) begin
                    bank_mem[b][bank_req[b].addr] = merge_bytes(
                        bank_mem[b][bank_req[b].addr], bank_req[b].wdata, bank_req[b].be);
                end
            end
        end
        if (row < N_ROWS && &done) begin
            row++;
            load_row();
        end
        next_bank_gnt();
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////

    task automatic build_table();
        // Interleaving from master 0 while master 1 contends for bank 0 right after reset
        stim[0]  = '{acc(1, 0, 32'h1C00_0000, 32'h1111_1111, 4'hF),
                     acc(1, 0, 32'h1C00_0010, 32'h5555_5555, 4'hF)};
        stim[1]  = '{acc(1, 0, 32'h1C00_0004, 32'h2222_2222, 4'hF), NOP};
        stim[2]  = '{acc(1, 0, 32'h1C00_0008, 32'h3333_3333, 4'hF), NOP};
        stim[3]  = '{acc(1, 0, 32'h1C00_000C, 32'h4444_4444, 4'hF), NOP};
        // Back-to-back reads from master 0
        stim[4]  = '{acc(0, 0, 32'h1C00_0000, 32'h0, 4'hF), NOP};
        stim[5]  = '{acc(0, 0, 32'h1C00_0004, 32'h0, 4'hF), NOP};
        stim[6]  = '{acc(0, 0, 32'h1C00_0008, 32'h0, 4'hF), NOP};
        stim[7]  = '{acc(0, 0, 32'h1C00_000C, 32'h0, 4'hF), NOP};
        stim[8]  = '{acc(1, 0, 32'h1C00_0010, 32'hAABB_CCDD, 4'h5), NOP};
        stim[9]  = '{acc(0, 0, 32'h1C00_0010, 32'h0, 4'hF), NOP};
        // Out-of-region accesses where the error write would alias word 0 of bank 1
        stim[10] = '{acc(0, 1, 32'h1C02_0000, 32'h0, 4'hF),
                     acc(1, 1, 32'h0000_1000, 32'h1234_5678, 4'hF)};
        stim[11] = '{acc(1, 1, 32'h1C02_0004, 32'hDEAD_BEEF, 4'hF),
                     acc(0, 0, 32'h1C00_0008, 32'h0, 4'hF)};
        stim[12] = '{acc(0, 0, 32'h1C00_0004, 32'h0, 4'hF),
                     acc(0, 1, 32'hFFFF_FFFC, 32'h0, 4'hF)};
        // Contention on bank 0
        stim[13] = '{acc(1, 0, 32'h1C00_0100, 32'hA0A0_A0A0, 4'hF),
                     acc(1, 0, 32'h1C00_0110, 32'hB1B1_B1B1, 4'hF)};
        stim[14] = '{acc(0, 0, 32'h1C00_0110, 32'h0, 4'hF),
                     acc(0, 0, 32'h1C00_0100, 32'h0, 4'hF)};
        // Different banks in parallel
        stim[15] = '{acc(0, 0, 32'h1C00_0100, 32'h0, 4'hF),
                     acc(0, 0, 32'h1C00_0114, 32'h0, 4'hF)};
        stim[16] = '{acc(1, 0, 32'h1C00_0208, 32'hC2C2_C2C2, 4'hF),
                     acc(1, 0, 32'h1C00_030C, 32'hD3D3_D3D3, 4'hF)};
        // Random bank back-pressure
        stim[17] = '{acc(0, 0, 32'h1C00_0208, 32'h0, 4'hF),
                     acc(0, 0, 32'h1C00_030C, 32'h0, 4'hF)};
        stim[18] = '{acc(1, 0, 32'h1C00_0400, 32'h0102_0304, 4'hF),
                     acc(1, 0, 32'h1C00_0404, 32'h0506_0708, 4'hF)};
        stim[19] = '{acc(0, 0, 32'h1C00_0404, 32'h0, 4'hF),
                     acc(0, 0, 32'h1C00_0400, 32'h0, 4'hF)};
        stim[20] = '{acc(1, 0, 32'h1C00_0500, 32'hF0F0_F0F0, 4'hF),
                     acc(0, 0, 32'h1C00_0500, 32'h0, 4'hF)};
        stim[21] = '{acc(0, 0, 32'h1C00_0000, 32'h0, 4'hF),
                     acc(0, 0, 32'h1C00_0010, 32'h0, 4'hF)};
        stim[22] = '{acc(0, 1, 32'h1C02_0000, 32'h0, 4'hF),
                     acc(0, 0, 32'h1C00_0004, 32'h0, 4'hF)};
        stim[23] = '{acc(0, 0, 32'h1C00_000C, 32'h0, 4'hF), NOP};
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Main sequence and timeout
    ////////////////////////////////////////////////////////////////////////

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        bank_gnt = '0;
        for (int m = 0; m < NM; m++) begin
            mst_req[m] = '0;
            exp_dat[m] = '0;
        end
        for (int b = 0; b < NB; b++) begin
            bank_rsp[b] = '0;
            rsp_nxt[b]  = '0;
            ptr[b]      = '0;
            for (int w = 0; w < BANK_WORDS; w++) begin
                bank_mem[b][w] = fill_word(soc_interconnect_pkg::INTLV_BASE[31:2] + w * NB + b);
            end
        end
        lfsr    = 16'd87;
        exp_vld = '0;
        exp_err = '0;
        exp_rd  = '0;
        row     = 0;
        build_table();
        load_row();
        next_bank_gnt();

        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        while (row < N_ROWS || |exp_vld) begin
            @(posedge clk);
            for (int m = 0; m < NM; m++) begin
                mst_req[m] <= drive_req(m);
            end
            bank_gnt <= gnt_nxt;
            for (int b = 0; b < NB; b++) begin
                bank_rsp[b] <= rsp_nxt[b];
            end
            @(negedge clk);
            check_and_advance();
        end

        $display(">>> PASS");
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles",
                CYCLE_LIMIT));
        end
    end

endmodule

//--- project.f
src/soc_interconnect_pkg.sv
src/tcdm_region_demux.sv
src/tcdm_error_slave.sv
src/bank_rr_arbiter.sv
src/interleaved_xbar.sv
src/soc_interconnect.sv
verification/tb_soc_interconnect.sv

//--- Bender.yml
package:
  name: soc_interconnect

sources:
  - src/soc_interconnect_pkg.sv
  - src/tcdm_region_demux.sv
  - src/tcdm_error_slave.sv
  - src/bank_rr_arbiter.sv
  - src/interleaved_xbar.sv
  - src/soc_interconnect.sv
  - target: test
    files:
      - verification/tb_soc_interconnect.sv
